// ==== hdl/sccb_pkg.sv ====
package sccb_pkg;

    // 8-bit write address of the sensor on the SCCB bus
    localparam logic [7:0] sccb_dev_id = 8'h78;

    // Device ID plus address high, address low and data
    localparam int sccb_bytes = 4;

    typedef struct packed {
        logic [15:0] reg_addr;                      // Sensor register address
        logic [7:0]  reg_data;                      // Value to write
    } sccb_entry_s;

    // The same 24 bits, as the table sees them and as the writer sends them
    typedef union packed {
        sccb_entry_s     entry;                     // Address/data view
        logic [2:0][7:0] bytes;                     // bytes[2] goes out first
    } sccb_frame_u;

endpackage

// ==== hdl/cam_cfg_pkg.sv ====
package cam_cfg_pkg;

    // Register table size and index
    localparam int cfg_entries = 20;
    typedef logic [4:0] cfg_index_t;

    // Output window defaults for 720p
    localparam logic [11:0] def_h_pixel = 12'd1280;
    localparam logic [11:0] def_v_pixel = 12'd720;

    // Total line and frame size including blanking
    localparam logic [12:0] def_total_h = 13'd2570;
    localparam logic [12:0] def_total_v = 13'd980;

    // 60 ms at 50 MHz before the first register write
    localparam logic [22:0] def_power_up_cycles = 23'd3_000_000;

    // 4 x 125 clocks per bit gives 100 kHz SCL
    localparam int def_quarter_cycles = 125;

endpackage

// ==== hdl/sccb_req_if.sv ====
`timescale 1ns/1ps

interface sccb_req_if import sccb_pkg::*; ();

    logic        start;                             // One-cycle request strobe
    sccb_frame_u frame;                             // Address and data of the entry
    logic        busy;                              // Frame in progress
    logic        done;                              // Pulse when busy falls

    // Configuration side
    modport cfg (
        output start,
        input  frame,
        input  busy,
        input  done
    );

    // Bus writer side
    modport bus (
        input  start,
        input  frame,
        output busy,
        output done
    );

endinterface

// ==== hdl/cfg_rom.sv ====
`timescale 1ns/1ps

module cfg_rom import sccb_pkg::*, cam_cfg_pkg::*; #(
    parameter logic [11:0] H_PIXEL = def_h_pixel,
    parameter logic [11:0] V_PIXEL = def_v_pixel,
    parameter logic [12:0] TOTAL_H = def_total_h,
    parameter logic [12:0] TOTAL_V = def_total_v
) (
    input  cfg_index_t  index,
    output sccb_frame_u frame
);

    always_comb begin
        case (index)
            // Soft reset, then back to normal mode
            5'd0:    frame.entry = {16'h3008, 8'h82};
            5'd1:    frame.entry = {16'h3008, 8'h02};
            5'd2:    frame.entry = {16'h3103, 8'h02};    // System clock from PLL
            5'd3:    frame.entry = {16'h3017, 8'hff};    // Sync and clock pins as outputs
            5'd4:    frame.entry = {16'h3018, 8'hff};    // Data pins as outputs
            5'd5:    frame.entry = {16'h3037, 8'h13};    // PLL root divider
            5'd6:    frame.entry = {16'h3108, 8'h01};    // System root divider
            5'd7:    frame.entry = {16'h4300, 8'h61};    // RGB565 output
            // Output size in pixels
            5'd8:    frame.entry = {16'h3808, 4'd0, H_PIXEL[11:8]};
            5'd9:    frame.entry = {16'h3809, H_PIXEL[7:0]};
            5'd10:   frame.entry = {16'h380a, 5'd0, V_PIXEL[10:8]};
            5'd11:   frame.entry = {16'h380b, V_PIXEL[7:0]};
            // Total size including blanking
            5'd12:   frame.entry = {16'h380c, 3'd0, TOTAL_H[12:8]};
            5'd13:   frame.entry = {16'h380d, TOTAL_H[7:0]};
            5'd14:   frame.entry = {16'h380e, 3'd0, TOTAL_V[12:8]};
            5'd15:   frame.entry = {16'h380f, TOTAL_V[7:0]};
            5'd16:   frame.entry = {16'h3035, 8'h11};    // System clock divider
            5'd17:   frame.entry = {16'h3036, 8'h5a};    // PLL multiplier
            5'd18:   frame.entry = {16'h501f, 8'h01};    // ISP format RGB
            5'd19:   frame.entry = {16'h503d, 8'h00};    // Colour bar test pattern off
            // A read-only ID register, so a stray write changes nothing
            default: frame.entry = {16'h300a, 8'h00};
        endcase
    end

endmodule

// ==== hdl/cfg_sequencer.sv ====
`timescale 1ns/1ps

module cfg_sequencer import cam_cfg_pkg::*; #(
    parameter logic [22:0] POWER_UP_CYCLES = def_power_up_cycles
) (
    input  logic       clk_50M,
    input  logic       rst_n,
    sccb_req_if.cfg    req,
    output cfg_index_t index,
    output logic       init_over
);

    localparam cfg_index_t last_index = cfg_index_t'(cfg_entries - 1);

    logic [22:0] pwr_cnt;
    logic        pwr_last;
    logic        last_done;
    logic        kick;

    assign pwr_last  = (pwr_cnt == POWER_UP_CYCLES - 23'd1);
    assign last_done = req.done && (index == last_index);

    always_ff @(posedge clk_50M or negedge rst_n) begin
        if (!rst_n) begin
            pwr_cnt <= '0;
        end else if (pwr_cnt != POWER_UP_CYCLES) begin
            pwr_cnt <= pwr_cnt + 23'd1;             // Saturates at the end of the delay
        end
    end

    always_ff @(posedge clk_50M or negedge rst_n) begin
        if (!rst_n) begin
            index     <= '0;
            kick      <= 1'b0;
            req.start <= 1'b0;
            init_over <= 1'b0;
        end else begin
            kick      <= pwr_last || (req.done && !last_done);
            req.start <= kick;                      // Table output has settled by now
            if (req.done && !last_done) begin
                index <= index + cfg_index_t'(1);
            end
            if (last_done) begin
                init_over <= 1'b1;                  // Held until the next reset
            end
        end
    end

    // The writer only takes a request while it is idle
    a_start_idle: assert property (@(posedge clk_50M) disable iff (!rst_n)
        !(req.start && req.busy))
        else $error("start raised while the SCCB writer is busy");

    a_init_hold: assert property (@(posedge clk_50M) disable iff (!rst_n)
        init_over |=> init_over)
        else $error("init_over fell without a reset");

endmodule

// ==== hdl/sccb_writer.sv ====
`timescale 1ns/1ps

module sccb_writer import sccb_pkg::*; #(
    parameter int QUARTER_CYCLES = 125
) (
    input  logic    clk_50M,
    input  logic    rst_n,
    sccb_req_if.bus req,
    output logic    scl,
    output logic    sda,
    output logic    sda_release
);

    localparam int QW = $clog2(QUARTER_CYCLES + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } state_t;

    state_t      state;
    logic [QW-1:0] qcnt;                            // Clocks within a quarter bit
    logic [1:0]  qtr;                               // Quarter within a bit
    logic [3:0]  bit_cnt;                           // 0..7 data, 8 is the released bit
    logic [1:0]  byte_cnt;                          // 0 is the device ID
    sccb_frame_u frame_q;
    logic        tick;
    logic        ack_bit;
    logic [7:0]  cur_byte;
    logic        scl_nxt;
    logic        sda_nxt;
    logic        rel_nxt;

    assign req.busy = (state != ST_IDLE);
    assign tick     = req.busy && (qcnt == QW'(QUARTER_CYCLES - 1));
    assign ack_bit  = (bit_cnt == 4'd8);
    assign cur_byte = (byte_cnt == 2'd0) ? sccb_dev_id : frame_q.bytes[2'd3 - byte_cnt];

    // Frame is latched on the start strobe and held for the whole transfer
    always_ff @(posedge clk_50M) begin
        if (req.start && !req.busy) begin
            frame_q <= req.frame;
        end
    end

    always_ff @(posedge clk_50M or negedge rst_n) begin
        if (!rst_n) begin
            qcnt <= '0;
        end else if (!req.busy || tick) begin
            qcnt <= '0;
        end else begin
            qcnt <= qcnt + QW'(1);
        end
    end

    always_ff @(posedge clk_50M or negedge rst_n) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            qtr      <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
            req.done <= 1'b0;
        end else begin
            req.done <= 1'b0;
            if (req.start && !req.busy) begin
                state    <= ST_START;
                qtr      <= '0;
                bit_cnt  <= '0;
                byte_cnt <= '0;
            end else if (tick) begin
                qtr <= qtr + 2'd1;
                if (qtr == 2'd3) begin              // End of a bit slot
                    case (state)
                        ST_START: state <= ST_DATA;
                        ST_DATA: begin
                            if (!ack_bit) begin
                                bit_cnt <= bit_cnt + 4'd1;
                            end else if (byte_cnt == 2'(sccb_bytes - 1)) begin
                                bit_cnt <= '0;
                                state   <= ST_STOP;
                            end else begin
                                bit_cnt  <= '0;
                                byte_cnt <= byte_cnt + 2'd1;
                            end
                        end
                        ST_STOP: begin
                            state    <= ST_IDLE;
                            req.done <= 1'b1;
                        end
                        default: state <= ST_IDLE;
                    endcase
                end
            end
        end
    end

    // Line levels for each quarter of the current slot
    always_comb begin
        scl_nxt = 1'b1;
        sda_nxt = 1'b1;
        rel_nxt = 1'b1;
        case (state)
            ST_START: begin
                rel_nxt = 1'b0;
                sda_nxt = (qtr == 2'd0);            // Falls in quarter 1 with scl high
                scl_nxt = (qtr != 2'd3);
            end
            ST_DATA: begin
                rel_nxt = ack_bit;                  // Slave may drive the ninth bit
                sda_nxt = ack_bit || cur_byte[3'd7 - bit_cnt[2:0]];
                scl_nxt = (qtr == 2'd1) || (qtr == 2'd2);
            end
            ST_STOP: begin
                rel_nxt = 1'b0;
                sda_nxt = qtr[1];                   // Rises in quarter 2 with scl high
                scl_nxt = (qtr != 2'd0);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_50M or negedge rst_n) begin
        if (!rst_n) begin
            scl         <= 1'b1;
            sda         <= 1'b1;
            sda_release <= 1'b1;
        end else begin
            scl         <= scl_nxt;
            sda         <= sda_nxt;
            sda_release <= rel_nxt;
        end
    end

    // Outputs trail the state by one clock
    a_sda_stable: assert property (@(posedge clk_50M) disable iff (!rst_n)
        (scl && $past(scl) && $changed(sda)) |-> ($past(state) inside {ST_START, ST_STOP}))
        else $error("sda changed while scl high outside start/stop");

    a_done_pulse: assert property (@(posedge clk_50M) disable iff (!rst_n)
        req.done |=> !req.done)
        else $error("done held for more than one cycle");

endmodule

// ==== hdl/cam_init_top.sv ====
`timescale 1ns/1ps

module cam_init_top import cam_cfg_pkg::*; #(
    parameter logic [22:0] POWER_UP_CYCLES = def_power_up_cycles,
    parameter int          QUARTER_CYCLES  = def_quarter_cycles,
    parameter logic [11:0] H_PIXEL         = def_h_pixel,
    parameter logic [11:0] V_PIXEL         = def_v_pixel,
    parameter logic [12:0] TOTAL_H         = def_total_h,
    parameter logic [12:0] TOTAL_V         = def_total_v
) (
    input  logic clk_50M,
    input  logic rst_n,
    output logic init_over,
    output logic scl,
    output logic sda,
    output logic sda_release
);

    cfg_index_t index;                              // Current table entry

    sccb_req_if req ();

    cfg_sequencer #(
        .POWER_UP_CYCLES (POWER_UP_CYCLES)
    ) i_seq (
        .clk_50M   (clk_50M),
        .rst_n     (rst_n),
        .req       (req.cfg),
        .index     (index),
        .init_over (init_over)
    );

    cfg_rom #(
        .H_PIXEL (H_PIXEL),
        .V_PIXEL (V_PIXEL),
        .TOTAL_H (TOTAL_H),
        .TOTAL_V (TOTAL_V)
    ) i_rom (
        .index (index),
        .frame (req.frame)
    );

    sccb_writer #(
        .QUARTER_CYCLES (QUARTER_CYCLES)
    ) i_writer (
        .clk_50M     (clk_50M),
        .rst_n       (rst_n),
        .req         (req.bus),
        .scl         (scl),
        .sda         (sda),
        .sda_release (sda_release)
    );

endmodule

// ==== test/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int RST_CYCLES = 10
) (
    output logic clk_50M,
    output logic por_n
);

    initial begin
        clk_50M = 1'b0;
        forever #10 clk_50M = ~clk_50M;             // 20 ns period
    end

    initial begin
        por_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_50M);
        #2 por_n = 1'b1;                            // Released just after an edge
    end

endmodule

// ==== test/tb_cam_init.sv ====
`timescale 1ns/1ps

module tb_cam_init import sccb_pkg::*, cam_cfg_pkg::*; ();

    localparam int PWR       = 200;
    localparam int QTR       = 4;
    localparam int FRAME_MAX = 40 * 4 * QTR;        // Upper bound on clocks per frame
    localparam int TIMEOUT   = 2 * (PWR + cfg_entries * FRAME_MAX);
    localparam logic [11:0] H_PIX = 12'd1920;
    localparam logic [11:0] V_PIX = 12'd1080;
    localparam logic [12:0] TOT_H = 13'd2844;
    localparam logic [12:0] TOT_V = 13'd1968;

    // Fixed entries, 0..7 then 16..19, as address and value
    localparam logic [23:0] FIXED [12] = '{
        24'h3008_82, 24'h3008_02, 24'h3103_02, 24'h3017_ff, 24'h3018_ff, 24'h3037_13,
        24'h3108_01, 24'h4300_61, 24'h3035_11, 24'h3036_5a, 24'h501f_01, 24'h503d_00
    };

    logic        clk_50M;
    logic        por_n;
    logic        mid_rst_n;
    logic        rst_n;
    logic        init_over;
    logic        scl;
    logic        sda;
    logic        sda_release;
    logic        line;
    logic        prev_scl;
    logic        prev_sda;
    logic        prev_line;
    logic        in_frame;
    logic [7:0]  shreg;
    logic [7:0]  got [4];
    logic [15:0] ref_addr [cfg_entries];
    logic [7:0]  ref_data [cfg_entries];
    logic [15:0] last_addr;
    logic [7:0]  last_data;
    int          bit_idx;
    int          byte_n;
    int          frame_n;
    int          starts;
    int          up_cnt;
    int          cyc;
    int          errs [1:6];
    int unsigned rst_cycle;

    assign rst_n = por_n && mid_rst_n;
    assign line  = sda_release || sda;              // Pull-up wins when released

    tb_clk_gen i_clk (
        .clk_50M (clk_50M),
        .por_n   (por_n)
    );

    cam_init_top #(
        .POWER_UP_CYCLES (23'(PWR)),
        .QUARTER_CYCLES  (QTR),
        .H_PIXEL         (H_PIX),
        .V_PIXEL         (V_PIX),
        .TOTAL_H         (TOT_H),
        .TOTAL_V         (TOT_V)
    ) i_dut (
        .clk_50M     (clk_50M),
        .rst_n       (rst_n),
        .init_over   (init_over),
        .scl         (scl),
        .sda         (sda),
        .sda_release (sda_release)
    );

    task automatic log_fail(input int test, input string msg);
        $display("Fail %0t ns test %0d: %s", $time, test, msg);
        errs[test]++;
    endtask

    task automatic report_test(input int test, input string name);
        $display("Test %0d %s: %0d errors", test, name, errs[test]);
    endtask

    function automatic void build_ref();
        for (int i = 0; i < 8; i++) begin
            {ref_addr[i], ref_data[i]} = FIXED[i];
            ref_addr[i + 8] = 16'h3808 + 16'(i);    // Size block is contiguous
        end
        for (int i = 0; i < 4; i++) begin
            {ref_addr[i + 16], ref_data[i + 16]} = FIXED[i + 8];
        end
        ref_data[8]  = 8'(H_PIX >> 8);
        ref_data[9]  = H_PIX[7:0];
        ref_data[10] = 8'(V_PIX[10:8]);
        ref_data[11] = V_PIX[7:0];
        ref_data[12] = 8'(TOT_H >> 8);
        ref_data[13] = TOT_H[7:0];
        ref_data[14] = 8'(TOT_V >> 8);
        ref_data[15] = TOT_V[7:0];
    endfunction

    // Stop clock pulse is sampled as one stray bit
    task automatic check_frame();
        assert (byte_n == sccb_bytes && bit_idx <= 1)
            else log_fail(2, $sformatf("frame %0d has %0d bytes", frame_n, byte_n));
        assert (got[0] == sccb_dev_id)
            else log_fail(2, $sformatf("frame %0d device ID %h", frame_n, got[0]));
        last_addr = {got[1], got[2]};
        last_data = got[3];
        if (frame_n < cfg_entries) begin
            assert (last_addr == ref_addr[frame_n] && last_data == ref_data[frame_n])
                else log_fail(3, $sformatf("frame %0d is %h/%h, expected %h/%h", frame_n,
                    last_addr, last_data, ref_addr[frame_n], ref_data[frame_n]));
        end else begin
            log_fail(5, $sformatf("extra frame %0d on the bus", frame_n));
        end
        frame_n++;
    endtask

    // Bus monitor, sampled mid-cycle where the registered pins are stable
    always @(negedge clk_50M) begin
        if (!rst_n) begin
            in_frame = 1'b0;
            frame_n  = 0;
            starts   = 0;
        end else if (scl && prev_scl && prev_line && !line) begin
            assert (!in_frame) else log_fail(2, "start condition inside a frame");
            in_frame = 1'b1;
            bit_idx  = 0;
            byte_n   = 0;
            starts++;
        end else if (scl && prev_scl && !prev_line && line) begin
            assert (in_frame) else log_fail(4, "stop condition outside a frame");
            if (in_frame) begin
                check_frame();
            end
            in_frame = 1'b0;
        end else if (scl && prev_scl) begin
            assert (sda == prev_sda) else log_fail(4, "sda changed while scl high");
        end else if (in_frame && scl && !prev_scl) begin
            if (bit_idx == 8) begin
                assert (sda_release) else log_fail(4, "sda not released in ninth bit");
                if (byte_n < 4) begin
                    got[byte_n] = shreg;
                end
                byte_n++;
                bit_idx = 0;
            end else begin
                shreg = {shreg[6:0], line};         // MSB first
                bit_idx++;
            end
        end
        prev_scl  = scl;
        prev_sda  = sda;
        prev_line = line;
    end

    always @(posedge clk_50M or negedge rst_n) begin
        if (!rst_n) begin
            up_cnt <= 0;
        end else if (up_cnt < PWR) begin
            up_cnt <= up_cnt + 1;
        end
    end

    a_quiet: assert property (@(posedge clk_50M) disable iff (!rst_n)
        (up_cnt < PWR) |-> (scl && sda && sda_release && !init_over))
        else log_fail(1, "bus active or init_over high in the power-up delay");

    a_hold: assert property (@(posedge clk_50M) disable iff (!rst_n)
        init_over |=> init_over)
        else log_fail(5, "init_over fell without a reset");

    a_idle: assert property (@(posedge clk_50M) disable iff (!rst_n)
        init_over |-> (scl && sda && sda_release))
        else log_fail(5, "bus not idle after init_over");

    always @(posedge clk_50M) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT) begin
            $display("Timeout: no result after %0d cycles", TIMEOUT);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        int total;
        int failed;
        mid_rst_n = 1'b1;
        total     = 0;
        failed    = 0;
        void'($urandom(32'h65c80a21));
        build_ref();
        wait (rst_n === 1'b1);
        // Somewhere in the first half of the register writes
        rst_cycle = PWR + 16 * QTR + ($urandom % (cfg_entries * FRAME_MAX / 2));
        repeat (rst_cycle) @(posedge clk_50M);
        #2 mid_rst_n = 1'b0;
        @(posedge clk_50M);
        assert (!init_over && scl && sda && sda_release)
            else log_fail(6, "outputs not cleared by the mid-run reset");
        repeat (3) @(posedge clk_50M);
        #2 mid_rst_n = 1'b1;
        wait (starts == 1);
        report_test(1, "power-up delay keeps the bus idle");
        wait (frame_n == 1);
        assert (last_addr == ref_addr[0] && last_data == ref_data[0])
            else log_fail(6, $sformatf("first frame after reset is %h/%h", last_addr, last_data));
        report_test(6, "mid-run reset restarts from entry 0");
        wait (init_over === 1'b1);
        assert (frame_n == cfg_entries)
            else log_fail(5, $sformatf("init_over after %0d frames", frame_n));
        report_test(2, "four bytes per frame with device ID");
        report_test(3, "frames match the register table");
        report_test(4, "released ninth bit and stable sda");
        repeat (2 * FRAME_MAX) @(posedge clk_50M);
        assert (starts == cfg_entries) else log_fail(5, "start condition after init_over");
        report_test(5, "frame count and idle bus after init_over");
        for (int t = 1; t <= 6; t++) begin
            total += errs[t];
            if (errs[t] != 0) begin
                failed++;
            end
        end
        $display("Summary: 6 tests, %0d failed, %0d errors", failed, total);
        if (total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== files.f ====
hdl/sccb_pkg.sv
hdl/cam_cfg_pkg.sv
hdl/sccb_req_if.sv
hdl/cfg_rom.sv
hdl/cfg_sequencer.sv
hdl/sccb_writer.sv
hdl/cam_init_top.sv
test/tb_clk_gen.sv
test/tb_cam_init.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_cam_init
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= -Wno-fatal
PASS_TEXT  ?= PASS: all tests

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary --timing --assert $(SIM_FLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
